/* hw/eth_pkg.sv */
/*
 * Ethernet protocol definitions: EtherType codes, address widths
 * and the frame header carried alongside each stream beat
 */
`default_nettype none

package eth_pkg;

  localparam int MAC_WIDTH = 48;
  localparam int ETHERTYPE_WIDTH = 16;

  localparam logic [ETHERTYPE_WIDTH-1:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [ETHERTYPE_WIDTH-1:0] ETHERTYPE_ARP = 16'h0806;

  // 112 bits, sampled on the first beat of a frame
  typedef struct packed {
    logic [MAC_WIDTH-1:0]       dest_mac;
    logic [MAC_WIDTH-1:0]       src_mac;
    logic [ETHERTYPE_WIDTH-1:0] eth_type;
  } eth_hdr_t;

endpackage

`default_nettype wire

/* hw/switch_pkg.sv */
/*
 * Switch datapath widths and the FSM encodings for routing and arbitration
 */
`default_nettype none

package switch_pkg;

  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;

  typedef enum logic [1:0] {
    ROUTE_IDLE,
    ROUTE_IP,
    ROUTE_ARP,
    ROUTE_DROP
  } route_e;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_IP,
    ARB_ARP
  } arb_state_e;

endpackage

`default_nettype wire

/* hw/eth_frame_if.sv */
/*
 * Frame stream with valid/ready handshake, header fields ride with every beat
 */
`timescale 1ns/1ns
`default_nettype none

interface eth_frame_if;

  logic [switch_pkg::DATA_WIDTH-1:0] tdata;
  logic [switch_pkg::KEEP_WIDTH-1:0] tkeep;
  logic                              tvalid;
  logic                              tready;
  logic                              tlast;
  logic                              tuser;
  // Constant across a frame
  eth_pkg::eth_hdr_t                 hdr;

  modport src (
    output tdata, tkeep, tvalid, tlast, tuser, hdr,
    input  tready
  );

  modport snk (
    input  tdata, tkeep, tvalid, tlast, tuser, hdr,
    output tready
  );

endinterface

`default_nettype wire

/* hw/eth_type_demux.sv */
/*
 * EtherType demux: routes received frames to the IP or ARP output,
 * swallows all other types, and holds the route for the whole frame
 */
`timescale 1ns/1ns
`default_nettype none

module eth_type_demux (
  input logic      clk,
  input logic      rst,
  eth_frame_if.snk in,
  eth_frame_if.src ip_out,
  eth_frame_if.src arp_out
);

  switch_pkg::route_e route_q;
  switch_pkg::route_e route_dec;
  switch_pkg::route_e route_cur;
  logic               in_xfer;

  always_comb begin
    if (in.hdr.eth_type == eth_pkg::ETHERTYPE_IPV4) begin
      route_dec = switch_pkg::ROUTE_IP;
    end else if (in.hdr.eth_type == eth_pkg::ETHERTYPE_ARP) begin
      route_dec = switch_pkg::ROUTE_ARP;
    end else begin
      route_dec = switch_pkg::ROUTE_DROP;
    end
  end

  // First beat decides directly so the path stays zero latency
  always_comb begin
    if (route_q != switch_pkg::ROUTE_IDLE) begin
      route_cur = route_q;
    end else if (in.tvalid) begin
      route_cur = route_dec;
    end else begin
      route_cur = switch_pkg::ROUTE_IDLE;
    end
  end

  assign in_xfer = in.tvalid && in.tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      route_q <= switch_pkg::ROUTE_IDLE;
    end else if (in_xfer && in.tlast) begin
      route_q <= switch_pkg::ROUTE_IDLE;
    end else if (route_q == switch_pkg::ROUTE_IDLE && in.tvalid) begin
      route_q <= route_dec;
    end
  end

  assign ip_out.tdata  = in.tdata;
  assign ip_out.tkeep  = in.tkeep;
  assign ip_out.tlast  = in.tlast;
  assign ip_out.tuser  = in.tuser;
  assign ip_out.hdr    = in.hdr;
  assign ip_out.tvalid = in.tvalid && (route_cur == switch_pkg::ROUTE_IP);

  assign arp_out.tdata  = in.tdata;
  assign arp_out.tkeep  = in.tkeep;
  assign arp_out.tlast  = in.tlast;
  assign arp_out.tuser  = in.tuser;
  assign arp_out.hdr    = in.hdr;
  assign arp_out.tvalid = in.tvalid && (route_cur == switch_pkg::ROUTE_ARP);

  // Dropped frames are drained at full rate
  assign in.tready = ((route_cur == switch_pkg::ROUTE_IP) && ip_out.tready) ||
                     ((route_cur == switch_pkg::ROUTE_ARP) && arp_out.tready) ||
                     (route_cur == switch_pkg::ROUTE_DROP);

  // Held route matches the EtherType of the frame in flight
  route_hold_a: assert property (
    @(posedge clk) disable iff (rst)
    (route_q != switch_pkg::ROUTE_IDLE && in.tvalid) |-> route_q == route_dec
  );

endmodule

`default_nettype wire

/* hw/frame_pipe_reg.sv */
/*
 * Two-entry skid register, registers both the forward path and tready
 * while still passing one beat per cycle
 */
`timescale 1ns/1ns
`default_nettype none

module frame_pipe_reg (
  input logic      clk,
  input logic      rst,
  eth_frame_if.snk in,
  eth_frame_if.src out
);

  typedef struct packed {
    logic [switch_pkg::DATA_WIDTH-1:0] tdata;
    logic [switch_pkg::KEEP_WIDTH-1:0] tkeep;
    logic                              tlast;
    logic                              tuser;
    eth_pkg::eth_hdr_t                 hdr;
  } beat_t;

  beat_t in_beat;
  beat_t main_q;
  beat_t skid_q;
  logic  main_valid;
  logic  skid_valid;
  logic  in_xfer;
  logic  load_main;

  assign in_beat = '{
    tdata: in.tdata,
    tkeep: in.tkeep,
    tlast: in.tlast,
    tuser: in.tuser,
    hdr:   in.hdr
  };

  // Skid only fills when main is full, so this is the both-full case
  assign in.tready = !skid_valid;
  assign in_xfer   = in.tvalid && in.tready;
  assign load_main = !main_valid || out.tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_main) begin
      main_valid <= skid_valid || in_xfer;
      skid_valid <= 1'b0;
    end else if (in_xfer) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) begin
      main_q <= skid_valid ? skid_q : in_beat;
    end
    if (!load_main && in_xfer) begin
      skid_q <= in_beat;
    end
  end

  assign out.tvalid = main_valid;
  assign out.tdata  = main_q.tdata;
  assign out.tkeep  = main_q.tkeep;
  assign out.tlast  = main_q.tlast;
  assign out.tuser  = main_q.tuser;
  assign out.hdr    = main_q.hdr;

  stall_hold_a: assert property (
    @(posedge clk) disable iff (rst)
    (out.tvalid && !out.tready) |=> out.tvalid
  );

endmodule

`default_nettype wire

/* hw/eth_frame_arb.sv */
/*
 * Two-input frame arbiter, ARP wins ties, grant held until the last beat
 */
`timescale 1ns/1ns
`default_nettype none

module eth_frame_arb (
  input logic      clk,
  input logic      rst,
  eth_frame_if.snk ip_in,
  eth_frame_if.snk arp_in,
  eth_frame_if.src out
);

  switch_pkg::arb_state_e state_q;
  logic                   frame_done;

  assign frame_done = out.tvalid && out.tready && out.tlast;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= switch_pkg::ARB_IDLE;
    end else begin
      case (state_q)
        switch_pkg::ARB_IDLE: begin
          if (arp_in.tvalid) begin
            state_q <= switch_pkg::ARB_ARP;
          end else if (ip_in.tvalid) begin
            state_q <= switch_pkg::ARB_IP;
          end
        end
        switch_pkg::ARB_IP,
        switch_pkg::ARB_ARP: begin
          if (frame_done) begin
            state_q <= switch_pkg::ARB_IDLE;
          end
        end
        default: state_q <= switch_pkg::ARB_IDLE;
      endcase
    end
  end

  always_comb begin
    case (state_q)
      switch_pkg::ARB_ARP: begin
        out.tvalid = arp_in.tvalid;
        out.tdata  = arp_in.tdata;
        out.tkeep  = arp_in.tkeep;
        out.tlast  = arp_in.tlast;
        out.tuser  = arp_in.tuser;
        out.hdr    = arp_in.hdr;
      end
      switch_pkg::ARB_IP: begin
        out.tvalid = ip_in.tvalid;
        out.tdata  = ip_in.tdata;
        out.tkeep  = ip_in.tkeep;
        out.tlast  = ip_in.tlast;
        out.tuser  = ip_in.tuser;
        out.hdr    = ip_in.hdr;
      end
      default: begin
        // No grant yet, keep the output quiet
        out.tvalid = 1'b0;
        out.tdata  = ip_in.tdata;
        out.tkeep  = ip_in.tkeep;
        out.tlast  = ip_in.tlast;
        out.tuser  = ip_in.tuser;
        out.hdr    = ip_in.hdr;
      end
    endcase
  end

  assign ip_in.tready  = (state_q == switch_pkg::ARB_IP) && out.tready;
  assign arp_in.tready = (state_q == switch_pkg::ARB_ARP) && out.tready;

  // Output header stays put until the granted frame ends
  grant_hold_a: assert property (
    @(posedge clk) disable iff (rst)
    (out.tvalid && !frame_done) |=> out.hdr == $past(out.hdr)
  );

endmodule

`default_nettype wire

/* hw/ip_stack_switch.sv */
/*
 * IP stack edge switch: EtherType demux on receive, ARP/IP merge on transmit
 */
`timescale 1ns/1ns
`default_nettype none

module ip_stack_switch (
  input  logic                                 clk,
  input  logic                                 rst,

  // Received Ethernet frames
  input  logic [switch_pkg::DATA_WIDTH-1:0]    s_eth_tdata,
  input  logic [switch_pkg::KEEP_WIDTH-1:0]    s_eth_tkeep,
  input  logic                                 s_eth_tvalid,
  output logic                                 s_eth_tready,
  input  logic                                 s_eth_tlast,
  input  logic                                 s_eth_tuser,
  input  logic [eth_pkg::MAC_WIDTH-1:0]        s_eth_dest_mac,
  input  logic [eth_pkg::MAC_WIDTH-1:0]        s_eth_src_mac,
  input  logic [eth_pkg::ETHERTYPE_WIDTH-1:0]  s_eth_type,

  // IPv4 receive output
  output logic [switch_pkg::DATA_WIDTH-1:0]    m_ip_rx_tdata,
  output logic [switch_pkg::KEEP_WIDTH-1:0]    m_ip_rx_tkeep,
  output logic                                 m_ip_rx_tvalid,
  input  logic                                 m_ip_rx_tready,
  output logic                                 m_ip_rx_tlast,
  output logic                                 m_ip_rx_tuser,
  output logic [eth_pkg::MAC_WIDTH-1:0]        m_ip_rx_dest_mac,
  output logic [eth_pkg::MAC_WIDTH-1:0]        m_ip_rx_src_mac,
  output logic [eth_pkg::ETHERTYPE_WIDTH-1:0]  m_ip_rx_type,

  // ARP receive output
  output logic [switch_pkg::DATA_WIDTH-1:0]    m_arp_rx_tdata,
  output logic [switch_pkg::KEEP_WIDTH-1:0]    m_arp_rx_tkeep,
  output logic                                 m_arp_rx_tvalid,
  input  logic                                 m_arp_rx_tready,
  output logic                                 m_arp_rx_tlast,
  output logic                                 m_arp_rx_tuser,
  output logic [eth_pkg::MAC_WIDTH-1:0]        m_arp_rx_dest_mac,
  output logic [eth_pkg::MAC_WIDTH-1:0]        m_arp_rx_src_mac,
  output logic [eth_pkg::ETHERTYPE_WIDTH-1:0]  m_arp_rx_type,

  // IPv4 transmit input
  input  logic [switch_pkg::DATA_WIDTH-1:0]    s_ip_tx_tdata,
  input  logic [switch_pkg::KEEP_WIDTH-1:0]    s_ip_tx_tkeep,
  input  logic                                 s_ip_tx_tvalid,
  output logic                                 s_ip_tx_tready,
  input  logic                                 s_ip_tx_tlast,
  input  logic                                 s_ip_tx_tuser,
  input  logic [eth_pkg::MAC_WIDTH-1:0]        s_ip_tx_dest_mac,
  input  logic [eth_pkg::MAC_WIDTH-1:0]        s_ip_tx_src_mac,
  input  logic [eth_pkg::ETHERTYPE_WIDTH-1:0]  s_ip_tx_type,

  // ARP transmit input
  input  logic [switch_pkg::DATA_WIDTH-1:0]    s_arp_tx_tdata,
  input  logic [switch_pkg::KEEP_WIDTH-1:0]    s_arp_tx_tkeep,
  input  logic                                 s_arp_tx_tvalid,
  output logic                                 s_arp_tx_tready,
  input  logic                                 s_arp_tx_tlast,
  input  logic                                 s_arp_tx_tuser,
  input  logic [eth_pkg::MAC_WIDTH-1:0]        s_arp_tx_dest_mac,
  input  logic [eth_pkg::MAC_WIDTH-1:0]        s_arp_tx_src_mac,
  input  logic [eth_pkg::ETHERTYPE_WIDTH-1:0]  s_arp_tx_type,

  // Merged Ethernet transmit output
  output logic [switch_pkg::DATA_WIDTH-1:0]    m_eth_tdata,
  output logic [switch_pkg::KEEP_WIDTH-1:0]    m_eth_tkeep,
  output logic                                 m_eth_tvalid,
  input  logic                                 m_eth_tready,
  output logic                                 m_eth_tlast,
  output logic                                 m_eth_tuser,
  output logic [eth_pkg::MAC_WIDTH-1:0]        m_eth_dest_mac,
  output logic [eth_pkg::MAC_WIDTH-1:0]        m_eth_src_mac,
  output logic [eth_pkg::ETHERTYPE_WIDTH-1:0]  m_eth_type
);

  eth_frame_if rx_if ();
  eth_frame_if ip_rx_if ();
  eth_frame_if arp_rx_if ();
  eth_frame_if ip_tx_if ();
  eth_frame_if arp_tx_if ();
  eth_frame_if arp_pipe_if ();
  eth_frame_if eth_tx_if ();

  assign rx_if.tdata  = s_eth_tdata;
  assign rx_if.tkeep  = s_eth_tkeep;
  assign rx_if.tvalid = s_eth_tvalid;
  assign rx_if.tlast  = s_eth_tlast;
  assign rx_if.tuser  = s_eth_tuser;
  assign rx_if.hdr    = {s_eth_dest_mac, s_eth_src_mac, s_eth_type};
  assign s_eth_tready = rx_if.tready;

  assign m_ip_rx_tdata     = ip_rx_if.tdata;
  assign m_ip_rx_tkeep     = ip_rx_if.tkeep;
  assign m_ip_rx_tvalid    = ip_rx_if.tvalid;
  assign m_ip_rx_tlast     = ip_rx_if.tlast;
  assign m_ip_rx_tuser     = ip_rx_if.tuser;
  assign m_ip_rx_dest_mac  = ip_rx_if.hdr.dest_mac;
  assign m_ip_rx_src_mac   = ip_rx_if.hdr.src_mac;
  assign m_ip_rx_type      = ip_rx_if.hdr.eth_type;
  assign ip_rx_if.tready   = m_ip_rx_tready;

  assign m_arp_rx_tdata    = arp_rx_if.tdata;
  assign m_arp_rx_tkeep    = arp_rx_if.tkeep;
  assign m_arp_rx_tvalid   = arp_rx_if.tvalid;
  assign m_arp_rx_tlast    = arp_rx_if.tlast;
  assign m_arp_rx_tuser    = arp_rx_if.tuser;
  assign m_arp_rx_dest_mac = arp_rx_if.hdr.dest_mac;
  assign m_arp_rx_src_mac  = arp_rx_if.hdr.src_mac;
  assign m_arp_rx_type     = arp_rx_if.hdr.eth_type;
  assign arp_rx_if.tready  = m_arp_rx_tready;

  assign ip_tx_if.tdata  = s_ip_tx_tdata;
  assign ip_tx_if.tkeep  = s_ip_tx_tkeep;
  assign ip_tx_if.tvalid = s_ip_tx_tvalid;
  assign ip_tx_if.tlast  = s_ip_tx_tlast;
  assign ip_tx_if.tuser  = s_ip_tx_tuser;
  assign ip_tx_if.hdr    = {s_ip_tx_dest_mac, s_ip_tx_src_mac, s_ip_tx_type};
  assign s_ip_tx_tready  = ip_tx_if.tready;

  assign arp_tx_if.tdata  = s_arp_tx_tdata;
  assign arp_tx_if.tkeep  = s_arp_tx_tkeep;
  assign arp_tx_if.tvalid = s_arp_tx_tvalid;
  assign arp_tx_if.tlast  = s_arp_tx_tlast;
  assign arp_tx_if.tuser  = s_arp_tx_tuser;
  assign arp_tx_if.hdr    = {s_arp_tx_dest_mac, s_arp_tx_src_mac, s_arp_tx_type};
  assign s_arp_tx_tready  = arp_tx_if.tready;

  assign m_eth_tdata      = eth_tx_if.tdata;
  assign m_eth_tkeep      = eth_tx_if.tkeep;
  assign m_eth_tvalid     = eth_tx_if.tvalid;
  assign m_eth_tlast      = eth_tx_if.tlast;
  assign m_eth_tuser      = eth_tx_if.tuser;
  assign m_eth_dest_mac   = eth_tx_if.hdr.dest_mac;
  assign m_eth_src_mac    = eth_tx_if.hdr.src_mac;
  assign m_eth_type       = eth_tx_if.hdr.eth_type;
  assign eth_tx_if.tready = m_eth_tready;

  eth_type_demux eth_type_demux_inst (
    .clk     (clk),
    .rst     (rst),
    .in      (rx_if.snk),
    .ip_out  (ip_rx_if.src),
    .arp_out (arp_rx_if.src)
  );

  // ARP transmit is registered before the merge
  frame_pipe_reg arp_tx_pipe_inst (
    .clk (clk),
    .rst (rst),
    .in  (arp_tx_if.snk),
    .out (arp_pipe_if.src)
  );

  eth_frame_arb eth_frame_arb_inst (
    .clk    (clk),
    .rst    (rst),
    .ip_in  (ip_tx_if.snk),
    .arp_in (arp_pipe_if.snk),
    .out    (eth_tx_if.src)
  );

endmodule

`default_nettype wire

/* tests/ip_stack_switch_tb.sv */
/*
 * Testbench for the IP stack edge switch: random frames on all three inputs,
 * random back-pressure on all three outputs, per-output scoreboards
 */
`timescale 1ns/1ns
`default_nettype none

module ip_stack_switch_tb;

  // Same field order as the concatenations used to drive and sample ports
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  keep;
    logic        last;
    logic        user;
    logic [47:0] dest_mac;
    logic [47:0] src_mac;
    logic [15:0] etype;
  } beat_t;

  logic        clk;
  logic        rst;
  logic [63:0] s_eth_tdata, m_ip_rx_tdata, m_arp_rx_tdata;
  logic [63:0] s_ip_tx_tdata, s_arp_tx_tdata, m_eth_tdata;
  logic [7:0]  s_eth_tkeep, m_ip_rx_tkeep, m_arp_rx_tkeep;
  logic [7:0]  s_ip_tx_tkeep, s_arp_tx_tkeep, m_eth_tkeep;
  logic        s_eth_tvalid, m_ip_rx_tvalid, m_arp_rx_tvalid;
  logic        s_ip_tx_tvalid, s_arp_tx_tvalid, m_eth_tvalid;
  logic        s_eth_tready, m_ip_rx_tready, m_arp_rx_tready;
  logic        s_ip_tx_tready, s_arp_tx_tready, m_eth_tready;
  logic        s_eth_tlast, m_ip_rx_tlast, m_arp_rx_tlast;
  logic        s_ip_tx_tlast, s_arp_tx_tlast, m_eth_tlast;
  logic        s_eth_tuser, m_ip_rx_tuser, m_arp_rx_tuser;
  logic        s_ip_tx_tuser, s_arp_tx_tuser, m_eth_tuser;
  logic [47:0] s_eth_dest_mac, m_ip_rx_dest_mac, m_arp_rx_dest_mac;
  logic [47:0] s_ip_tx_dest_mac, s_arp_tx_dest_mac, m_eth_dest_mac;
  logic [47:0] s_eth_src_mac, m_ip_rx_src_mac, m_arp_rx_src_mac;
  logic [47:0] s_ip_tx_src_mac, s_arp_tx_src_mac, m_eth_src_mac;
  logic [15:0] s_eth_type, m_ip_rx_type, m_arp_rx_type;
  logic [15:0] s_ip_tx_type, s_arp_tx_type, m_eth_type;

  logic [15:0] lfsr_state = 16'd40;
  int          value_errs = 0;
  int          other_errs = 0;

  // Sources 0 s_eth, 1 s_ip_tx, 2 s_arp_tx
  beat_t send_q [3][$];
  logic  gap_q [3][$];
  // Outputs 0 m_ip_rx, 1 m_arp_rx, 2 m_eth from IP, 3 m_eth from ARP
  beat_t exp_q [4][$];
  string out_names [4] = '{"m_ip_rx", "m_arp_rx", "m_eth (IP)", "m_eth (ARP)"};

  ip_stack_switch ip_stack_switch_inst (.*);

  // Taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  // Reference route: 0 none, 1 IP, 2 ARP
  function automatic int expected_route(input logic [15:0] etype);
    if (etype == 16'h0800) return 1;
    if (etype == 16'h0806) return 2;
    return 0;
  endfunction

  task automatic make_frame(input int src, input logic [15:0] etype, input int exp_idx);
    logic [63:0] v;
    beat_t       b;
    int          len;
    take_bits(3, v);
    len = int'(v[2:0]) + 1;
    take_bits(48, v);
    b.dest_mac = v[47:0];
    take_bits(48, v);
    b.src_mac = v[47:0];
    b.etype = etype;
    for (int i = 0; i < len; i++) begin
      take_bits(64, v);
      b.data = v;
      b.last = (i == len - 1);
      take_bits(3, v);
      b.keep = b.last ? (8'hff >> v[2:0]) : 8'hff;
      take_bits(1, v);
      b.user = b.last & v[0];
      send_q[src].push_back(b);
      take_bits(2, v);
      gap_q[src].push_back(v[1:0] == 2'b00);
      if (exp_idx >= 0) begin
        exp_q[exp_idx].push_back(b);
      end
    end
  endtask

  task automatic drive_source(input int s, input logic valid, input beat_t b);
    case (s)
      0: begin
        s_eth_tvalid <= valid;
        {s_eth_tdata, s_eth_tkeep, s_eth_tlast, s_eth_tuser,
         s_eth_dest_mac, s_eth_src_mac, s_eth_type} <= b;
      end
      1: begin
        s_ip_tx_tvalid <= valid;
        {s_ip_tx_tdata, s_ip_tx_tkeep, s_ip_tx_tlast, s_ip_tx_tuser,
         s_ip_tx_dest_mac, s_ip_tx_src_mac, s_ip_tx_type} <= b;
      end
      default: begin
        s_arp_tx_tvalid <= valid;
        {s_arp_tx_tdata, s_arp_tx_tkeep, s_arp_tx_tlast, s_arp_tx_tuser,
         s_arp_tx_dest_mac, s_arp_tx_src_mac, s_arp_tx_type} <= b;
      end
    endcase
  endtask

  function automatic logic source_ready(input int s);
    case (s)
      0: return s_eth_tready;
      1: return s_ip_tx_tready;
      default: return s_arp_tx_tready;
    endcase
  endfunction

  function automatic int pending_beats();
    int n;
    n = 0;
    for (int i = 0; i < 4; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  task automatic check_beat(input int idx, input beat_t got);
    beat_t exp;
    assert (exp_q[idx].size() > 0) else begin
      $display("Unexpected beat on %s at time %0t", out_names[idx], $time);
      other_errs++;
    end
    if (exp_q[idx].size() > 0) begin
      exp = exp_q[idx].pop_front();
      assert (got == exp) else begin
        $display("** Error at %0t: %s beat %h, expected %h", $time, out_names[idx], got, exp);
        value_errs++;
      end
    end
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // Sinks ready about three cycles out of four
  initial begin : ready_gen
    logic [63:0] v;
    m_ip_rx_tready = 1'b0;
    m_arp_rx_tready = 1'b0;
    m_eth_tready = 1'b0;
    forever begin
      @(posedge clk);
      take_bits(2, v);
      m_ip_rx_tready <= |v[1:0];
      take_bits(2, v);
      m_arp_rx_tready <= |v[1:0];
      take_bits(2, v);
      m_eth_tready <= |v[1:0];
    end
  end

  initial begin : compare
    int          rst_cycles;
    logic        eth_open;
    logic [15:0] eth_open_type;
    rst_cycles = 0;
    eth_open = 1'b0;
    eth_open_type = '0;
    forever begin
      @(posedge clk);
      if (rst) begin
        rst_cycles++;
        if (rst_cycles > 1) begin
          assert (!m_ip_rx_tvalid && !m_arp_rx_tvalid && !m_eth_tvalid) else begin
            $display("Output tvalid high during reset at time %0t", $time);
            other_errs++;
          end
        end
      end else begin
        if (m_ip_rx_tvalid && m_ip_rx_tready) begin
          check_beat(0, {m_ip_rx_tdata, m_ip_rx_tkeep, m_ip_rx_tlast, m_ip_rx_tuser,
                         m_ip_rx_dest_mac, m_ip_rx_src_mac, m_ip_rx_type});
        end
        if (m_arp_rx_tvalid && m_arp_rx_tready) begin
          check_beat(1, {m_arp_rx_tdata, m_arp_rx_tkeep, m_arp_rx_tlast, m_arp_rx_tuser,
                         m_arp_rx_dest_mac, m_arp_rx_src_mac, m_arp_rx_type});
        end
        if (m_eth_tvalid && m_eth_tready) begin
          if (eth_open) begin
            assert (m_eth_type == eth_open_type) else begin
              $display("Frames interleaved on m_eth at time %0t", $time);
              other_errs++;
            end
          end
          check_beat((m_eth_type == 16'h0806) ? 3 : 2,
                     {m_eth_tdata, m_eth_tkeep, m_eth_tlast, m_eth_tuser,
                      m_eth_dest_mac, m_eth_src_mac, m_eth_type});
          eth_open = !m_eth_tlast;
          eth_open_type = m_eth_type;
        end
        // Dropped frames must never back-pressure the input
        if (s_eth_tvalid && expected_route(s_eth_type) == 0) begin
          assert (s_eth_tready) else begin
            $display("Input stalled on a dropped frame at time %0t", $time);
            other_errs++;
          end
        end
      end
    end
  end

  initial begin : main_seq
    logic [63:0] v;
    logic [15:0] etype;
    beat_t       cur [3];
    logic        busy [3];
    logic        left;
    int          cycles;
    rst = 1'b1;
    for (int s = 0; s < 3; s++) begin
      cur[s] = '0;
      busy[s] = 1'b0;
      drive_source(s, 1'b0, cur[s]);
    end
    for (int f = 0; f < 40; f++) begin
      take_bits(2, v);
      if (v[1:0] == 2'd1) begin
        etype = 16'h0806;
      end else if (v[1:0] == 2'd2) begin
        take_bits(16, v);
        etype = v[15:0];
      end else begin
        etype = 16'h0800;
      end
      make_frame(0, etype, expected_route(etype) - 1);
    end
    for (int f = 0; f < 30; f++) begin
      make_frame(1, 16'h0800, 2);
      make_frame(2, 16'h0806, 3);
    end

    repeat (8) @(posedge clk);
    rst <= 1'b0;

    cycles = 0;
    left = 1'b1;
    while (left && cycles < 20000) begin
      @(posedge clk);
      cycles++;
      left = 1'b0;
      for (int s = 0; s < 3; s++) begin
        if (busy[s] && source_ready(s)) begin
          busy[s] = 1'b0;
        end
        if (!busy[s]) begin
          if (send_q[s].size() == 0 || gap_q[s][0]) begin
            if (send_q[s].size() > 0) begin
              gap_q[s][0] = 1'b0;
            end
            drive_source(s, 1'b0, cur[s]);
          end else begin
            cur[s] = send_q[s].pop_front();
            gap_q[s].delete(0);
            drive_source(s, 1'b1, cur[s]);
            busy[s] = 1'b1;
          end
        end
        if (busy[s] || send_q[s].size() > 0) begin
          left = 1'b1;
        end
      end
    end
    assert (!left) else begin
      $display("Timed out sending stimulus, inputs stopped accepting beats");
      other_errs++;
    end

    cycles = 0;
    while (pending_beats() > 0 && cycles < 5000) begin
      @(posedge clk);
      cycles++;
    end
    assert (pending_beats() == 0) else begin
      $display("Timed out with %0d expected beats never seen on the outputs", pending_beats());
      other_errs++;
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ip_stack_switch.f */
hw/eth_pkg.sv
hw/switch_pkg.sv
hw/eth_frame_if.sv
hw/eth_type_demux.sv
hw/frame_pipe_reg.sv
hw/eth_frame_arb.sv
hw/ip_stack_switch.sv
tests/ip_stack_switch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f ip_stack_switch.f \
  --top-module ip_stack_switch_tb -o ip_stack_switch_sim || exit 1
sim_out=$(./obj_dir/ip_stack_switch_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation PASSED" && exit 0 || exit 1
